//--- sim.f
design/axi_mem_pkg.sv
design/axi_req_bridge.sv
design/axi_arbiter.sv
design/axi_sram_slave.sv
design/axi_mem_top.sv
tb/tb_axi_mem_top.sv

//--- Makefile
# Verilator build and run for the shared AXI memory

VERILATOR ?= verilator
TOP       ?= tb_axi_mem_top
LOG       ?= sim.log
ARGS      ?=
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP LOG ARGS OBJ_DIR"

$(OBJ_DIR)/V$(TOP): sim.f $(shell cat sim.f)
	$(VERILATOR) --binary --assert -Wno-fatal --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f sim.f $(ARGS)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_axi_mem_top.sv
// Shared AXI memory testbench
module tb_axi_mem_top
  import axi_mem_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LINE_WORDS     = 4;
  localparam int MEM_WORDS      = 1024;
  localparam int N_RAND         = 200;
  localparam int N_TXN          = 240;
  localparam int TIMEOUT_FACTOR = 400;
  localparam logic [31:0] SEED  = 32'hb2b960bc;

  typedef struct packed {
    logic         we;
    logic [31:0]  addr;
    logic [127:0] wdata;
    logic [15:0]  wstrb;
    logic [2:0]   gap;
  } txn_t;

  logic         i_aclk = 1'b0;
  logic         i_reset;
  logic         i_line_req, i_word_req;
  mem_cmd_t     i_line_cmd, i_word_cmd;
  logic [127:0] i_line_wdata, o_line_rdata;
  logic [15:0]  i_line_wstrb;
  logic [31:0]  i_word_wdata, o_word_rdata;
  logic [3:0]   i_word_wstrb;
  logic         o_line_ack, o_line_err, o_word_ack, o_word_err;

  logic [31:0]  shadow [MEM_WORDS];
  logic [31:0]  lfsr_state = SEED;
  logic [127:0] exp_line_data;
  logic [31:0]  exp_word_data;
  logic         exp_line_err, exp_line_rd, exp_word_err, exp_word_rd;
  logic         line_ack_d = 1'b0;
  logic         word_ack_d = 1'b0;
  int           n_checks = 0;
  int           n_errors = 0;
  txn_t         line_txns [N_RAND/2];
  txn_t         word_txns [N_RAND/2];

  axi_mem_top i_axi_mem_top (.*);

  always #4 i_aclk = ~i_aclk;

  // --------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) lfsr_state = lfsr_state ^ 32'hd0000001;
      val = {val[30:0], out};
    end
    return val;
  endfunction

  // Word after the access; out of range reads zero and flags an error
  function automatic logic [31:0] model_word(input int unsigned idx, input logic we,
                                             input logic [31:0] wd, input logic [3:0] ws,
                                             output logic err);
    logic [31:0] mask;
    err = (idx >= MEM_WORDS);
    if (err) return '0;
    mask = {{8{ws[3]}}, {8{ws[2]}}, {8{ws[1]}}, {8{ws[0]}}};
    if (we) shadow[idx] = (shadow[idx] & ~mask) | (wd & mask);
    return shadow[idx];
  endfunction

  function automatic logic [31:0] fill_word(input int unsigned idx);
    logic [31:0] a;
    a = idx * 4;
    return a ^ {a[15:0], a[31:16]} ^ 32'h5ac33ca5;
  endfunction

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic plan_line(input txn_t t);
    logic        e;
    int unsigned base;
    base = t.addr >> 2;
    exp_line_err = 1'b0;
    exp_line_rd  = !t.we;
    for (int i = 0; i < LINE_WORDS; i++) begin
      exp_line_data[32*i +: 32] = model_word(base + i, t.we, t.wdata[32*i +: 32],
                                             t.wstrb[4*i +: 4], e);
      exp_line_err = exp_line_err | e;
    end
  endtask

  task automatic plan_word(input txn_t t);
    exp_word_rd   = !t.we;
    exp_word_data = model_word(t.addr >> 2, t.we, t.wdata[31:0], t.wstrb[3:0], exp_word_err);
  endtask

  task automatic run_line(input txn_t t);
    @(posedge i_aclk);
    i_line_req   <= 1'b1;
    i_line_cmd   <= '{we: t.we, addr: t.addr};
    i_line_wdata <= t.wdata;
    i_line_wstrb <= t.wstrb;
    @(posedge i_aclk);
    while (!o_line_ack) @(posedge i_aclk);
    i_line_req <= 1'b0;
    @(posedge i_aclk);
    while (o_line_ack) @(posedge i_aclk);
  endtask

  task automatic run_word(input txn_t t);
    @(posedge i_aclk);
    i_word_req   <= 1'b1;
    i_word_cmd   <= '{we: t.we, addr: t.addr};
    i_word_wdata <= t.wdata[31:0];
    i_word_wstrb <= t.wstrb[3:0];
    @(posedge i_aclk);
    while (!o_word_ack) @(posedge i_aclk);
    i_word_req <= 1'b0;
    @(posedge i_aclk);
    while (o_word_ack) @(posedge i_aclk);
  endtask

  task automatic line_op(input logic we, input int unsigned idx, input logic [127:0] wd,
                         input logic [15:0] ws);
    txn_t t;
    t = '{we: we, addr: idx * 4, wdata: wd, wstrb: ws, gap: 3'd0};
    plan_line(t);
    run_line(t);
  endtask

  task automatic word_op(input logic we, input int unsigned idx, input logic [31:0] wd,
                         input logic [3:0] ws);
    txn_t t;
    t = '{we: we, addr: idx * 4, wdata: {96'd0, wd}, wstrb: {12'd0, ws}, gap: 3'd0};
    plan_word(t);
    run_word(t);
  endtask

  // Line port uses words 0..31, word port 32..63, 1 in 16 out of range
  function automatic txn_t make_txn(input logic line);
    txn_t        t;
    int unsigned idx;
    logic        oor;
    t.we  = rand_bits(1);
    idx   = line ? rand_bits(3) * 4 : 32 + rand_bits(5);
    oor   = (rand_bits(4) == 0);
    t.addr = (idx + (oor ? MEM_WORDS : 0)) * 4;
    for (int k = 0; k < 4; k++) t.wdata[32*k +: 32] = rand_bits(32);
    t.wstrb = rand_bits(16);
    t.gap   = rand_bits(3);
    return t;
  endfunction

  // --------------------------------------------------
  // Response compare on each rising ack
  // --------------------------------------------------
  always @(posedge i_aclk) begin
    line_ack_d <= o_line_ack;
    word_ack_d <= o_word_ack;
    if (o_line_ack && !line_ack_d) begin
      check_val("o_line_err", exp_line_err, o_line_err);
      if (exp_line_rd) check_val("o_line_rdata", exp_line_data, o_line_rdata);
    end
    if (o_word_ack && !word_ack_d) begin
      check_val("o_word_err", exp_word_err, o_word_err);
      if (exp_word_rd) check_val("o_word_rdata", exp_word_data, o_word_rdata);
    end
  end

  initial begin
    repeat (TIMEOUT_FACTOR * N_TXN) @(posedge i_aclk);
    $display("Timeout: transactions did not complete within %0d cycles",
             TIMEOUT_FACTOR * N_TXN);
    $display("TEST FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    txn_t tl;
    txn_t tw;
    i_reset    <= 1'b1;
    i_line_req <= 1'b0;
    i_word_req <= 1'b0;
    i_line_cmd <= '0;
    i_word_cmd <= '0;
    i_line_wdata <= '0;
    i_line_wstrb <= '0;
    i_word_wdata <= '0;
    i_word_wstrb <= '0;
    repeat (3) @(posedge i_aclk);
    i_reset <= 1'b0;
    @(posedge i_aclk);
    check_val("o_line_ack", 1'b0, o_line_ack);
    check_val("o_word_ack", 1'b0, o_word_ack);

    // Word write, partial strobe merge, read back
    word_op(1'b1, 100, 32'h11223344, 4'hf);
    word_op(1'b1, 100, 32'haabbccdd, 4'b0101);
    word_op(1'b0, 100, '0, '0);

    line_op(1'b1, 200, 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0, 16'hffff);
    line_op(1'b0, 200, '0, '0);

    // Word port wins last, so the line port takes the next tie
    word_op(1'b0, 100, '0, '0);
    tl = '{we: 1'b1, addr: 300 * 4, wdata: 128'h01234567_89abcdef_fedcba98_76543210,
           wstrb: 16'hffff, gap: 3'd0};
    tw = '{we: 1'b1, addr: 301 * 4, wdata: {96'd0, 32'hdeadbeef}, wstrb: 16'h0003,
           gap: 3'd0};
    plan_line(tl);
    plan_word(tw);
    fork
      run_line(tl);
      run_word(tw);
    join
    tl.we = 1'b0;
    tw.we = 1'b0;
    plan_line(tl);
    plan_word(tw);
    fork
      run_line(tl);
      run_word(tw);
    join

    for (int l = 0; l < 16; l++) begin
      for (int k = 0; k < 4; k++) tl.wdata[32*k +: 32] = fill_word(l * 4 + k);
      line_op(1'b1, l * 4, tl.wdata, 16'hffff);
    end

    // Out of range aliases low words if unguarded
    line_op(1'b1, MEM_WORDS, {4{32'hbad0bad0}}, 16'hffff);
    word_op(1'b1, MEM_WORDS + 33, 32'hbad1bad1, 4'hf);
    word_op(1'b0, MEM_WORDS + 5, '0, '0);
    line_op(1'b0, 0, '0, '0);
    word_op(1'b0, 33, '0, '0);

    for (int i = 0; i < N_RAND / 2; i++) begin
      line_txns[i] = make_txn(1'b1);
      word_txns[i] = make_txn(1'b0);
    end
    fork
      for (int i = 0; i < N_RAND / 2; i++) begin
        repeat (line_txns[i].gap) @(posedge i_aclk);
        plan_line(line_txns[i]);
        run_line(line_txns[i]);
      end
      for (int i = 0; i < N_RAND / 2; i++) begin
        repeat (word_txns[i].gap) @(posedge i_aclk);
        plan_word(word_txns[i]);
        run_word(word_txns[i]);
      end
    join

    repeat (2) @(posedge i_aclk);
    $display("Checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- design/axi_mem_top.sv
// Shared AXI memory top
module axi_mem_top
  import axi_mem_pkg::*;
#(
  parameter int LINE_WORDS = 4,
  parameter int MEM_WORDS  = 1024
) (
  input  logic                             i_aclk,
  input  logic                             i_reset,
  // Line port
  input  logic                             i_line_req,
  input  mem_cmd_t                         i_line_cmd,
  input  logic [LINE_WORDS*AXI_DATA_W-1:0] i_line_wdata,
  input  logic [LINE_WORDS*AXI_STRB_W-1:0] i_line_wstrb,
  output logic                             o_line_ack,
  output logic                             o_line_err,
  output logic [LINE_WORDS*AXI_DATA_W-1:0] o_line_rdata,
  // Word port
  input  logic                             i_word_req,
  input  mem_cmd_t                         i_word_cmd,
  input  logic [AXI_DATA_W-1:0]            i_word_wdata,
  input  logic [AXI_STRB_W-1:0]            i_word_wstrb,
  output logic                             o_word_ack,
  output logic                             o_word_err,
  output logic [AXI_DATA_W-1:0]            o_word_rdata
);

  // Master 0 is the line port, master 1 the word port
  logic    [1:0] m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
  logic    [1:0] m_arvalid, m_arready, m_rvalid, m_rready;
  axi_aw_t [1:0] m_aw;
  axi_w_t  [1:0] m_w;
  axi_b_t  [1:0] m_b;
  axi_ar_t [1:0] m_ar;
  axi_r_t  [1:0] m_r;

  logic          s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic          s_arvalid, s_arready, s_rvalid, s_rready;
  axi_aw_t       s_aw;
  axi_w_t        s_w;
  axi_b_t        s_b;
  axi_ar_t       s_ar;
  axi_r_t        s_r;

  axi_req_bridge #(
    .LINE_WORDS (LINE_WORDS)
  ) u_line_bridge (
    .i_aclk    (i_aclk),
    .i_reset   (i_reset),
    .i_req     (i_line_req),
    .i_cmd     (i_line_cmd),
    .i_wdata   (i_line_wdata),
    .i_wstrb   (i_line_wstrb),
    .o_ack     (o_line_ack),
    .o_err     (o_line_err),
    .o_rdata   (o_line_rdata),
    .o_awvalid (m_awvalid[0]),
    .i_awready (m_awready[0]),
    .o_aw      (m_aw[0]),
    .o_wvalid  (m_wvalid[0]),
    .i_wready  (m_wready[0]),
    .o_w       (m_w[0]),
    .i_bvalid  (m_bvalid[0]),
    .o_bready  (m_bready[0]),
    .i_b       (m_b[0]),
    .o_arvalid (m_arvalid[0]),
    .i_arready (m_arready[0]),
    .o_ar      (m_ar[0]),
    .i_rvalid  (m_rvalid[0]),
    .o_rready  (m_rready[0]),
    .i_r       (m_r[0])
  );

  axi_req_bridge #(
    .LINE_WORDS (1)
  ) u_word_bridge (
    .i_aclk    (i_aclk),
    .i_reset   (i_reset),
    .i_req     (i_word_req),
    .i_cmd     (i_word_cmd),
    .i_wdata   (i_word_wdata),
    .i_wstrb   (i_word_wstrb),
    .o_ack     (o_word_ack),
    .o_err     (o_word_err),
    .o_rdata   (o_word_rdata),
    .o_awvalid (m_awvalid[1]),
    .i_awready (m_awready[1]),
    .o_aw      (m_aw[1]),
    .o_wvalid  (m_wvalid[1]),
    .i_wready  (m_wready[1]),
    .o_w       (m_w[1]),
    .i_bvalid  (m_bvalid[1]),
    .o_bready  (m_bready[1]),
    .i_b       (m_b[1]),
    .o_arvalid (m_arvalid[1]),
    .i_arready (m_arready[1]),
    .o_ar      (m_ar[1]),
    .i_rvalid  (m_rvalid[1]),
    .o_rready  (m_rready[1]),
    .i_r       (m_r[1])
  );

  axi_arbiter u_arbiter (
    .i_aclk      (i_aclk),
    .i_reset     (i_reset),
    .i_m_awvalid (m_awvalid),
    .o_m_awready (m_awready),
    .i_m_aw      (m_aw),
    .i_m_wvalid  (m_wvalid),
    .o_m_wready  (m_wready),
    .i_m_w       (m_w),
    .o_m_bvalid  (m_bvalid),
    .i_m_bready  (m_bready),
    .o_m_b       (m_b),
    .i_m_arvalid (m_arvalid),
    .o_m_arready (m_arready),
    .i_m_ar      (m_ar),
    .o_m_rvalid  (m_rvalid),
    .i_m_rready  (m_rready),
    .o_m_r       (m_r),
    .o_s_awvalid (s_awvalid),
    .i_s_awready (s_awready),
    .o_s_aw      (s_aw),
    .o_s_wvalid  (s_wvalid),
    .i_s_wready  (s_wready),
    .o_s_w       (s_w),
    .i_s_bvalid  (s_bvalid),
    .o_s_bready  (s_bready),
    .i_s_b       (s_b),
    .o_s_arvalid (s_arvalid),
    .i_s_arready (s_arready),
    .o_s_ar      (s_ar),
    .i_s_rvalid  (s_rvalid),
    .o_s_rready  (s_rready),
    .i_s_r       (s_r)
  );

  axi_sram_slave #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .i_aclk    (i_aclk),
    .i_reset   (i_reset),
    .i_awvalid (s_awvalid),
    .o_awready (s_awready),
    .i_aw      (s_aw),
    .i_wvalid  (s_wvalid),
    .o_wready  (s_wready),
    .i_w       (s_w),
    .o_bvalid  (s_bvalid),
    .i_bready  (s_bready),
    .o_b       (s_b),
    .i_arvalid (s_arvalid),
    .o_arready (s_arready),
    .i_ar      (s_ar),
    .o_rvalid  (s_rvalid),
    .i_rready  (s_rready),
    .o_r       (s_r)
  );

endmodule

//--- design/axi_sram_slave.sv
// AXI4 SRAM slave
module axi_sram_slave
  import axi_mem_pkg::*;
#(
  parameter int MEM_WORDS = 1024
) (
  input  logic    i_aclk,
  input  logic    i_reset,
  input  logic    i_awvalid,
  output logic    o_awready,
  input  axi_aw_t i_aw,
  input  logic    i_wvalid,
  output logic    o_wready,
  input  axi_w_t  i_w,
  output logic    o_bvalid,
  input  logic    i_bready,
  output axi_b_t  o_b,
  input  logic    i_arvalid,
  output logic    o_arready,
  input  axi_ar_t i_ar,
  output logic    o_rvalid,
  input  logic    i_rready,
  output axi_r_t  o_r
);

  typedef enum logic {RD_IDLE, RD_READ} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_WRITE, WR_RESP} wr_state_e;

  localparam int IDX_W  = $clog2(MEM_WORDS);
  localparam int LANE_W = $clog2(AXI_STRB_W);
  localparam int WORD_W = AXI_ADDR_W - LANE_W;

  logic [AXI_DATA_W-1:0] mem [MEM_WORDS];

  rd_state_e             rd_state;
  wr_state_e             wr_state;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;
  logic                  ar_fire;
  logic                  r_fire;

  logic [AXI_ID_W-1:0]   rd_id;
  logic [7:0]            rd_len;
  logic [7:0]            rd_cnt;
  logic [WORD_W-1:0]     rd_idx;
  logic [WORD_W-1:0]     rd_next;
  logic [AXI_DATA_W-1:0] rd_data;
  logic                  rd_err;
  logic                  rd_bad;

  logic [AXI_ID_W-1:0]   wr_id;
  logic [7:0]            wr_len;
  logic [7:0]            wr_cnt;
  logic [WORD_W-1:0]     wr_idx;
  logic                  wr_in;
  logic                  wr_err;

  function automatic logic in_range(input logic [WORD_W-1:0] idx);
    return idx < WORD_W'(MEM_WORDS);
  endfunction

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid  & o_wready;
  assign b_fire  = o_bvalid  & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid  & i_rready;

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (ar_fire) rd_state <= RD_READ;
        RD_READ: if (r_fire && o_r.last) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  assign rd_next = ar_fire ? i_ar.addr[AXI_ADDR_W-1:LANE_W] : rd_idx + 1'b1;

  // Fetch the next beat ahead so rdata holds while rready is low
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rd_id  <= i_ar.id;
      rd_len <= i_ar.len;
      rd_bad <= (i_ar.burst != BURST_INCR);
    end
    if (ar_fire || (r_fire && !o_r.last)) begin
      rd_idx  <= rd_next;
      rd_cnt  <= ar_fire ? 8'd0 : rd_cnt + 8'd1;
      rd_err  <= !in_range(rd_next);
      rd_data <= in_range(rd_next) ? mem[rd_next[IDX_W-1:0]] : '0;
    end
  end

  assign o_arready = (rd_state == RD_IDLE);
  assign o_rvalid  = (rd_state == RD_READ);
  assign o_r.id    = rd_id;
  assign o_r.data  = rd_data;
  assign o_r.resp  = (rd_err || rd_bad) ? RESP_SLVERR : RESP_OKAY;
  assign o_r.last  = (rd_cnt == rd_len);

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE:  if (aw_fire) wr_state <= WR_WRITE;
        WR_WRITE: if (w_fire && i_w.last) wr_state <= WR_RESP;
        WR_RESP:  if (b_fire) wr_state <= WR_IDLE;
        default:  wr_state <= WR_IDLE;
      endcase
    end
  end

  assign wr_in = in_range(wr_idx);

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      wr_id  <= i_aw.id;
      wr_len <= i_aw.len;
      wr_cnt <= '0;
      wr_idx <= i_aw.addr[AXI_ADDR_W-1:LANE_W];
      wr_err <= (i_aw.burst != BURST_INCR);
    end else if (w_fire) begin
      wr_idx <= wr_idx + 1'b1;
      wr_cnt <= wr_cnt + 8'd1;
      if (!wr_in) begin
        wr_err <= 1'b1;
      end
    end
  end

  // Byte lanes merge under the strobes
  always_ff @(posedge i_aclk) begin
    if (w_fire && wr_in) begin
      for (int b = 0; b < AXI_STRB_W; b++) begin
        if (i_w.strb[b]) begin
          mem[wr_idx[IDX_W-1:0]][8*b +: 8] <= i_w.data[8*b +: 8];
        end
      end
    end
  end

  assign o_awready = (wr_state == WR_IDLE);
  assign o_wready  = (wr_state == WR_WRITE);
  assign o_bvalid  = (wr_state == WR_RESP);
  assign o_b.id    = wr_id;
  assign o_b.resp  = wr_err ? RESP_SLVERR : RESP_OKAY;

  // Master's wlast lines up with the AW length
  a_wlast_len: assert property (@(posedge i_aclk) disable iff (i_reset)
    w_fire |-> (i_w.last == (wr_cnt == wr_len)));

endmodule

//--- design/axi_arbiter.sv
// Round-robin AXI arbiter
module axi_arbiter
  import axi_mem_pkg::*;
(
  input  logic          i_aclk,
  input  logic          i_reset,
  // Master side
  input  logic    [1:0] i_m_awvalid,
  output logic    [1:0] o_m_awready,
  input  axi_aw_t [1:0] i_m_aw,
  input  logic    [1:0] i_m_wvalid,
  output logic    [1:0] o_m_wready,
  input  axi_w_t  [1:0] i_m_w,
  output logic    [1:0] o_m_bvalid,
  input  logic    [1:0] i_m_bready,
  output axi_b_t  [1:0] o_m_b,
  input  logic    [1:0] i_m_arvalid,
  output logic    [1:0] o_m_arready,
  input  axi_ar_t [1:0] i_m_ar,
  output logic    [1:0] o_m_rvalid,
  input  logic    [1:0] i_m_rready,
  output axi_r_t  [1:0] o_m_r,
  // Slave side
  output logic          o_s_awvalid,
  input  logic          i_s_awready,
  output axi_aw_t       o_s_aw,
  output logic          o_s_wvalid,
  input  logic          i_s_wready,
  output axi_w_t        o_s_w,
  input  logic          i_s_bvalid,
  output logic          o_s_bready,
  input  axi_b_t        i_s_b,
  output logic          o_s_arvalid,
  input  logic          i_s_arready,
  output axi_ar_t       o_s_ar,
  input  logic          i_s_rvalid,
  output logic          o_s_rready,
  input  axi_r_t        i_s_r
);

  typedef enum logic [1:0] {IDLE, READ, WRITE} state_e;

  state_e     state;
  logic       owner;
  logic [1:0] want;
  logic       pick;
  logic       b_dst;
  logic       r_dst;

  assign want  = i_m_awvalid | i_m_arvalid;
  // On a tie the master that did not win last time goes first
  assign pick  = (want == 2'b11) ? ~owner : want[1];
  assign b_dst = i_s_b.id[0];
  assign r_dst = i_s_r.id[0];

  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      state <= IDLE;
      owner <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (|want) begin
            owner <= pick;
            state <= i_m_awvalid[pick] ? WRITE : READ;
          end
        end
        READ:    if (i_s_rvalid && o_s_rready && i_s_r.last) state <= IDLE;
        WRITE:   if (i_s_bvalid && o_s_bready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Channel steering
  // --------------------------------------------------
  always_comb begin
    o_s_aw      = i_m_aw[owner];
    o_s_aw.id   = AXI_ID_W'(owner);
    o_s_ar      = i_m_ar[owner];
    o_s_ar.id   = AXI_ID_W'(owner);
    o_s_w       = i_m_w[owner];
    o_m_b       = {2{i_s_b}};
    o_m_r       = {2{i_s_r}};
    o_s_awvalid = 1'b0;
    o_s_wvalid  = 1'b0;
    o_s_bready  = 1'b0;
    o_s_arvalid = 1'b0;
    o_s_rready  = 1'b0;
    o_m_awready = '0;
    o_m_wready  = '0;
    o_m_bvalid  = '0;
    o_m_arready = '0;
    o_m_rvalid  = '0;
    case (state)
      WRITE: begin
        o_s_awvalid        = i_m_awvalid[owner];
        o_m_awready[owner] = i_s_awready;
        o_s_wvalid         = i_m_wvalid[owner];
        o_m_wready[owner]  = i_s_wready;
        o_s_bready         = i_m_bready[b_dst];
        o_m_bvalid[b_dst]  = i_s_bvalid;
      end
      READ: begin
        o_s_arvalid        = i_m_arvalid[owner];
        o_m_arready[owner] = i_s_arready;
        o_s_rready         = i_m_rready[r_dst];
        o_m_rvalid[r_dst]  = i_s_rvalid;
      end
      default: ;
    endcase
  end

  // Slave must echo the ID stamped at grant
  a_resp_id: assert property (@(posedge i_aclk) disable iff (i_reset)
    (i_s_rvalid || i_s_bvalid) |->
      ((i_s_rvalid ? i_s_r.id : i_s_b.id) == AXI_ID_W'(owner)));

endmodule

//--- design/axi_req_bridge.sv
// Client to AXI master bridge
module axi_req_bridge
  import axi_mem_pkg::*;
#(
  parameter int LINE_WORDS = 4
) (
  input  logic                             i_aclk,
  input  logic                             i_reset,
  // Client port
  input  logic                             i_req,
  input  mem_cmd_t                         i_cmd,
  input  logic [LINE_WORDS*AXI_DATA_W-1:0] i_wdata,
  input  logic [LINE_WORDS*AXI_STRB_W-1:0] i_wstrb,
  output logic                             o_ack,
  output logic                             o_err,
  output logic [LINE_WORDS*AXI_DATA_W-1:0] o_rdata,
  // AXI master
  output logic                             o_awvalid,
  input  logic                             i_awready,
  output axi_aw_t                          o_aw,
  output logic                             o_wvalid,
  input  logic                             i_wready,
  output axi_w_t                           o_w,
  input  logic                             i_bvalid,
  output logic                             o_bready,
  input  axi_b_t                           i_b,
  output logic                             o_arvalid,
  input  logic                             i_arready,
  output axi_ar_t                          o_ar,
  input  logic                             i_rvalid,
  output logic                             o_rready,
  input  axi_r_t                           i_r
);

  typedef enum logic [2:0] {IDLE, ADDR, DATA, RESP, ACK, WAIT_LOW} state_e;

  localparam logic [7:0] LAST_BEAT = 8'(LINE_WORDS - 1);
  localparam logic [2:0] BEAT_SIZE = 3'($clog2(AXI_STRB_W));

  state_e     state;
  logic [7:0] beat;
  logic       aw_fire;
  logic       w_fire;
  logic       b_fire;
  logic       ar_fire;
  logic       r_fire;

  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid  & i_wready;
  assign b_fire  = i_bvalid  & o_bready;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = i_rvalid  & o_rready;

  assign o_awvalid = (state == ADDR) &&  i_cmd.we;
  assign o_arvalid = (state == ADDR) && !i_cmd.we;
  assign o_wvalid  = (state == DATA) &&  i_cmd.we;
  assign o_rready  = (state == DATA) && !i_cmd.we;
  assign o_bready  = (state == RESP);
  assign o_ack     = (state == ACK);

  // ID is left at zero, the arbiter stamps it
  assign o_aw = '{id: '0, addr: i_cmd.addr, len: LAST_BEAT, size: BEAT_SIZE, burst: BURST_INCR};
  assign o_ar = '{id: '0, addr: i_cmd.addr, len: LAST_BEAT, size: BEAT_SIZE, burst: BURST_INCR};

  // Slice the current beat out of the line
  assign o_w.data = i_wdata[beat*AXI_DATA_W +: AXI_DATA_W];
  assign o_w.strb = i_wstrb[beat*AXI_STRB_W +: AXI_STRB_W];
  assign o_w.last = (beat == LAST_BEAT);

  // --------------------------------------------------
  // Transaction FSM
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:     if (i_req) state <= ADDR;
        ADDR:     if (aw_fire || ar_fire) state <= DATA;
        DATA: begin
          if (w_fire && o_w.last) begin
            state <= RESP;
          end else if (r_fire && i_r.last) begin
            state <= ACK;
          end
        end
        RESP:     if (b_fire) state <= ACK;
        ACK:      if (!i_req) state <= WAIT_LOW;
        WAIT_LOW: state <= IDLE;
        default:  state <= IDLE;
      endcase
    end
  end

  // Beat count and error collection
  always_ff @(posedge i_aclk) begin
    if (i_reset || state == IDLE) begin
      beat  <= '0;
      o_err <= 1'b0;
    end else begin
      if (w_fire || r_fire) begin
        beat <= beat + 8'd1;
      end
      if ((r_fire && i_r.resp == RESP_SLVERR) || (b_fire && i_b.resp == RESP_SLVERR)) begin
        o_err <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (r_fire) begin
      o_rdata[beat*AXI_DATA_W +: AXI_DATA_W] <= i_r.data;
    end
  end

  // Client holds its command for the whole request
  a_cmd_stable: assert property (@(posedge i_aclk) disable iff (i_reset)
    (i_req && $past(i_req) && !$past(o_ack)) |-> $stable(i_cmd));

endmodule

//--- design/axi_mem_pkg.sv
// Shared memory AXI definitions
package axi_mem_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  // --------------------------------------------------
  // Protocol codes
  // --------------------------------------------------
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // --------------------------------------------------
  // Channel payloads
  // --------------------------------------------------
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    axi_burst_e            burst;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    axi_burst_e            burst;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    axi_resp_e           resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    axi_resp_e             resp;
    logic                  last;
  } axi_r_t;

  // Client request, byte addressed
  typedef struct packed {
    logic                  we;
    logic [AXI_ADDR_W-1:0] addr;
  } mem_cmd_t;

endpackage
